// File: sim.f
+incdir+.
exec_pkg.sv
issue_dispatch.sv
exec_lane.sv
reorder_buffer.sv
exec_cluster.sv
exec_cluster_checker.sv
tb_exec_cluster.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exec_cluster -f sim.f -o tb_exec_cluster

./obj_dir/tb_exec_cluster +verilator+error+limit+1000 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
grep -q "=== PASS ===" sim.log

// File: tb_exec_cluster.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module tb_exec_cluster;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int LATENCY    = `EXEC_LANE_DEPTH + 3;  // accept negedge to retire negedge
  localparam int N_STREAM   = 60;
  localparam int N_GAPPY    = 80;
  localparam int STALL_HOLD = 12;
  localparam int CYC_SINGLE = 4 + 2 * LATENCY;
  localparam int CYC_STREAM = N_STREAM + 2 * LATENCY;
  localparam int CYC_FILL   = 2 * `EXEC_ROB_DEPTH + STALL_HOLD + 2 * LATENCY;
  localparam int CYC_GAPPY  = 8 * N_GAPPY + 4 * LATENCY;
  localparam int TIMEOUT    = 2 + CYC_SINGLE + CYC_STREAM + CYC_FILL + CYC_GAPPY + 200;

  logic                    clock;
  logic                    reset;
  logic                    issue_valid;
  exec_pkg::alu_op_t       issue_op;
  logic [`EXEC_DATA_W-1:0] issue_a;
  logic [`EXEC_DATA_W-1:0] issue_b;
  logic                    issue_ready;
  logic                    retire_stall;
  logic                    retire_valid;
  logic [`EXEC_TAG_W-1:0]  retire_tag;
  logic [`EXEC_DATA_W-1:0] retire_data;

  logic [31:0] rng_state = 32'd58;
  int cycle_count       = 0;
  int error_count       = 0;
  int accept_count      = 0;
  int retire_count      = 0;
  int tag_count         = 0;
  int last_accept_cycle = 0;
  bit check_latency     = 1'b0;
  bit random_stall      = 1'b0;

  // expected results in issue order
  logic [`EXEC_DATA_W-1:0] exp_data_q [$];
  logic [`EXEC_TAG_W-1:0]  exp_tag_q [$];

  exec_cluster dut_i (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .issue_ready  (issue_ready),
    .retire_stall (retire_stall),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .retire_data  (retire_data)
  );

  bind exec_cluster exec_cluster_checker checker_i (
    .clock        (clock),
    .reset        (reset),
    .issue_ready  (issue_ready),
    .rob_full     (rob_full),
    .retire_valid (retire_valid),
    .retire_stall (retire_stall),
    .lane_valid   (lane_valid),
    .done_valid   (done_valid)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [`EXEC_DATA_W-1:0] expected_result(
    input exec_pkg::alu_op_t       op,
    input logic [`EXEC_DATA_W-1:0] a,
    input logic [`EXEC_DATA_W-1:0] b
  );
    logic [2*`EXEC_DATA_W-1:0] prod;
    prod = {{`EXEC_DATA_W{1'b0}}, a} * {{`EXEC_DATA_W{1'b0}}, b};
    case (op)
      exec_pkg::op_add: return a + b;
      exec_pkg::op_sub: return a - b;
      exec_pkg::op_and: return a & b;
      exec_pkg::op_xor: return a ^ b;
      exec_pkg::op_mul: return prod[`EXEC_DATA_W-1:0];  // low half
      default:          return '0;
    endcase
  endfunction

  task automatic load_random_op();
    logic [31:0] r;
    r = next_rand();
    issue_op = exec_pkg::alu_op_t'(3'(r % 5));
    issue_a  = next_rand();
    issue_b  = next_rand();
  endtask

  // one clock with the handshake sampled mid cycle
  task automatic clock_step(output bit took);
    @(negedge clock);
    took = issue_valid && issue_ready;
    @(posedge clock);
    #DRIVE_DLY;
    if (random_stall) begin
      retire_stall = (next_rand() % 4) == 0;
    end
  endtask

  task automatic idle_cycles(input int n);
    bit took;
    repeat (n) clock_step(took);
  endtask

  task automatic send_random_op();
    bit took;
    load_random_op();
    issue_valid = 1'b1;
    took = 1'b0;
    while (!took) clock_step(took);
    issue_valid = 1'b0;
  endtask

  task automatic wait_drained();
    bit took;
    while (exp_data_q.size() != 0) clock_step(took);
  endtask

  task automatic check_retirement();
    logic [`EXEC_DATA_W-1:0] exp_data;
    logic [`EXEC_TAG_W-1:0]  exp_tag;
    retire_count++;
    assert (exp_data_q.size() != 0) else begin
      error_count++;
      $display("a result retired while no operation was pending");
    end
    if (exp_data_q.size() != 0) begin
      exp_data = exp_data_q.pop_front();
      exp_tag  = exp_tag_q.pop_front();
      assert (retire_data === exp_data) else begin
        error_count++;
        $display("FAILED retire_data: expected %h, got %h", exp_data, retire_data);
      end
      assert (retire_tag === exp_tag) else begin
        error_count++;
        $display("FAILED retire_tag: expected %h, got %h", exp_tag, retire_tag);
      end
      if (check_latency) begin
        assert (cycle_count == last_accept_cycle + LATENCY) else begin
          error_count++;
          $display("retire came %0d cycles after acceptance instead of %0d",
                   cycle_count - last_accept_cycle, LATENCY);
        end
      end
    end
  endtask

  // scoreboard runs at the falling edge where everything is settled
  always @(negedge clock) begin
    if (!reset && issue_valid && issue_ready) begin
      exp_data_q.push_back(expected_result(issue_op, issue_a, issue_b));
      exp_tag_q.push_back(`EXEC_TAG_W'(tag_count % `EXEC_ROB_DEPTH));
      tag_count++;
      accept_count++;
      last_accept_cycle = cycle_count;
    end
    if (!reset && retire_valid) begin
      check_retirement();
    end
  end

  initial begin
    while (cycle_count < TIMEOUT) @(negedge clock);
    $display("timeout after %0d cycles with %0d results pending", cycle_count,
             exp_data_q.size());
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    bit took;
    bit full_seen;
    int start_accepts;
    int start_retires;
    int total_errors;
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue_op     = exec_pkg::op_add;
    issue_a      = '0;
    issue_b      = '0;
    retire_stall = 1'b0;
    repeat (2) @(posedge clock);
    #DRIVE_DLY;
    reset = 1'b0;

    @(negedge clock);
    assert (issue_ready === 1'b1 && retire_valid === 1'b0) else begin
      error_count++;
      $display("cluster not idle after reset");
    end
    @(posedge clock);
    #DRIVE_DLY;

    // lone add with fixed latency and tag 0
    check_latency = 1'b1;
    issue_op    = exec_pkg::op_add;
    issue_a     = next_rand();
    issue_b     = next_rand();
    issue_valid = 1'b1;
    took = 1'b0;
    while (!took) clock_step(took);
    issue_valid = 1'b0;
    wait_drained();
    check_latency = 1'b0;

    // back to back stream wraps the tags
    repeat (N_STREAM) send_random_op();
    wait_drained();

    // fill under stall
    start_accepts = accept_count;
    start_retires = retire_count;
    retire_stall  = 1'b1;
    issue_valid   = 1'b1;
    full_seen     = 1'b0;
    while (!full_seen) begin
      load_random_op();
      clock_step(took);
      full_seen = !took;
    end
    issue_valid = 1'b0;
    assert (accept_count - start_accepts == `EXEC_ROB_DEPTH) else begin
      error_count++;
      $display("issue_ready fell after %0d acceptances instead of %0d",
               accept_count - start_accepts, `EXEC_ROB_DEPTH);
    end
    repeat (STALL_HOLD) begin
      clock_step(took);
      assert (!issue_ready) else begin
        error_count++;
        $display("issue_ready rose while the buffer was full and stalled");
      end
    end
    assert (retire_count == start_retires) else begin
      error_count++;
      $display("results retired while retire_stall was held");
    end
    retire_stall = 1'b0;
    wait_drained();
    clock_step(took);
    assert (issue_ready === 1'b1) else begin
      error_count++;
      $display("issue_ready did not return after the drain");
    end

    // gaps and stall toggling
    random_stall = 1'b1;
    repeat (N_GAPPY) begin
      idle_cycles(next_rand() % 4);
      send_random_op();
    end
    random_stall = 1'b0;
    retire_stall = 1'b0;
    wait_drained();
    idle_cycles(2 * LATENCY);  // catch stray retirements
    assert (accept_count == retire_count) else begin
      error_count++;
      $display("accepted %0d operations but retired %0d", accept_count, retire_count);
    end

    total_errors = error_count + dut_i.checker_i.fail_count;
    $display("errors: scoreboard %0d, assertions %0d (accepted %0d, retired %0d)",
             error_count, dut_i.checker_i.fail_count, accept_count, retire_count);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: exec_cluster_checker.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_cluster_checker (
  input                        clock,
  input                        reset,
  input                        issue_ready,
  input                        rob_full,
  input                        retire_valid,
  input                        retire_stall,
  input  [`EXEC_NUM_LANES-1:0] lane_valid,
  input  [`EXEC_NUM_LANES-1:0] done_valid
);

  int fail_count = 0;  // failed assertions so far

  //////////////////////////////////////////////////
  // retire side
  //////////////////////////////////////////////////
  stall_blocks_retire_a: assert property (
    @(posedge clock) disable iff (reset) retire_stall |-> !retire_valid
  ) else begin
    fail_count = fail_count + 1;
    $error("retire_valid was high while retire_stall was high");
  end

  idle_after_reset_a: assert property (
    @(posedge clock) reset |=> (!retire_valid && issue_ready)
  ) else begin
    fail_count = fail_count + 1;
    $error("cluster not idle in the cycle after reset");
  end

  //////////////////////////////////////////////////
  // issue and lanes
  //////////////////////////////////////////////////
  ready_tracks_full_a: assert property (
    @(posedge clock) disable iff (reset) issue_ready == !rob_full
  ) else begin
    fail_count = fail_count + 1;
    $error("issue_ready does not match the inverse of rob_full");
  end

  // one lane per cycle at most
  lane_onehot_a: assert property (
    @(posedge clock) disable iff (reset) $onehot0(lane_valid)
  ) else begin
    fail_count = fail_count + 1;
    $error("more than one lane_valid bit high");
  end

  lanes_quiet_after_reset_a: assert property (
    @(posedge clock) reset |=> (lane_valid == '0 && done_valid == '0)
  ) else begin
    fail_count = fail_count + 1;
    $error("lane strobes active in the cycle after reset");
  end

endmodule

// File: exec_cluster.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_cluster (
  input                            clock,
  input                            reset,
  // issue
  input                            issue_valid,
  input  exec_pkg::alu_op_t        issue_op,
  input        [`EXEC_DATA_W-1:0]  issue_a,
  input        [`EXEC_DATA_W-1:0]  issue_b,
  output logic                     issue_ready,
  // retire
  input                            retire_stall,
  output logic                     retire_valid,
  output logic [`EXEC_TAG_W-1:0]   retire_tag,
  output logic [`EXEC_DATA_W-1:0]  retire_data
);

  // dispatcher and rob handshake
  logic                   rob_full;
  logic                   alloc;
  logic [`EXEC_TAG_W-1:0] alloc_tag;

  // dispatcher to lanes
  logic [`EXEC_NUM_LANES-1:0] lane_valid;
  exec_pkg::alu_op_t          lane_op;
  logic [`EXEC_DATA_W-1:0]    lane_a;
  logic [`EXEC_DATA_W-1:0]    lane_b;
  logic [`EXEC_TAG_W-1:0]     lane_tag;

  // lanes to rob
  logic [`EXEC_NUM_LANES-1:0]                    done_valid;
  logic [`EXEC_NUM_LANES-1:0][`EXEC_TAG_W-1:0]   done_tag;
  logic [`EXEC_NUM_LANES-1:0][`EXEC_DATA_W-1:0]  done_data;

  issue_dispatch dispatch_i (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_ready (issue_ready),
    .rob_full    (rob_full),
    .alloc_tag   (alloc_tag),
    .alloc       (alloc),
    .lane_valid  (lane_valid),
    .lane_op     (lane_op),
    .lane_a      (lane_a),
    .lane_b      (lane_b),
    .lane_tag    (lane_tag)
  );

  //////////////////////////////////////////////////
  // execution lanes
  //////////////////////////////////////////////////
  for (genvar l = 0; l < `EXEC_NUM_LANES; l++) begin : lane_g
    exec_lane lane_i (
      .clock     (clock),
      .reset     (reset),
      .in_valid  (lane_valid[l]),  // own slot only
      .in_op     (lane_op),
      .in_a      (lane_a),
      .in_b      (lane_b),
      .in_tag    (lane_tag),
      .out_valid (done_valid[l]),
      .out_tag   (done_tag[l]),
      .out_data  (done_data[l])
    );
  end

  reorder_buffer rob_i (
    .clock        (clock),
    .reset        (reset),
    .alloc        (alloc),
    .alloc_tag    (alloc_tag),
    .rob_full     (rob_full),
    .done_valid   (done_valid),
    .done_tag     (done_tag),
    .done_data    (done_data),
    .retire_stall (retire_stall),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .retire_data  (retire_data)
  );

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module reorder_buffer (
  input                                                 clock,
  input                                                 reset,
  // allocation
  input                                                 alloc,
  output logic [`EXEC_TAG_W-1:0]                        alloc_tag,
  output logic                                          rob_full,
  // completions, one slot per lane
  input        [`EXEC_NUM_LANES-1:0]                    done_valid,
  input        [`EXEC_NUM_LANES-1:0][`EXEC_TAG_W-1:0]   done_tag,
  input        [`EXEC_NUM_LANES-1:0][`EXEC_DATA_W-1:0]  done_data,
  // retirement
  input                                                 retire_stall,
  output logic                                          retire_valid,
  output logic [`EXEC_TAG_W-1:0]                        retire_tag,
  output logic [`EXEC_DATA_W-1:0]                       retire_data
);

  localparam logic [`EXEC_TAG_W:0] FULL_COUNT = `EXEC_ROB_DEPTH;

  exec_pkg::entry_state_t  state_q [`EXEC_ROB_DEPTH];
  logic [`EXEC_DATA_W-1:0] data_q  [`EXEC_ROB_DEPTH];

  logic [`EXEC_TAG_W-1:0]  head_q;
  logic [`EXEC_TAG_W-1:0]  tail_q;
  logic [`EXEC_TAG_W-1:0]  head_nxt;
  logic [`EXEC_TAG_W:0]    count_q;
  logic                    head_rdy_q;  // head seen done one cycle earlier
  logic                    retire;

  assign alloc_tag = tail_q;
  assign rob_full  = (count_q == FULL_COUNT);
  assign head_nxt  = head_q + 1'b1;  // wraps, depth is a power of two

  //////////////////////////////////////////////////
  // retire port
  //////////////////////////////////////////////////
  assign retire       = head_rdy_q && !retire_stall;
  assign retire_valid = retire;
  assign retire_tag   = head_q;
  assign retire_data  = data_q[head_q];

  // pointers and occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      head_rdy_q <= 1'b0;
    end else begin
      if (alloc) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q     <= head_nxt;
        head_rdy_q <= (state_q[head_nxt] == exec_pkg::st_done);
      end else begin
        head_rdy_q <= (state_q[head_q] == exec_pkg::st_done);
      end
      case ({alloc, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////
  // entry state
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `EXEC_ROB_DEPTH; i++) begin
        state_q[i] <= exec_pkg::st_empty;
      end
    end else begin
      if (alloc) begin
        state_q[tail_q] <= exec_pkg::st_waiting;
      end
      // several lanes may finish together
      for (int l = 0; l < `EXEC_NUM_LANES; l++) begin
        if (done_valid[l]) begin
          state_q[done_tag[l]] <= exec_pkg::st_done;
        end
      end
      if (retire) begin
        state_q[head_q] <= exec_pkg::st_empty;
      end
    end
  end

  // result storage
  always_ff @(posedge clock) begin
    for (int l = 0; l < `EXEC_NUM_LANES; l++) begin
      if (done_valid[l]) begin
        data_q[done_tag[l]] <= done_data[l];
      end
    end
  end

endmodule

// File: exec_lane.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_lane (
  input                            clock,
  input                            reset,
  // from dispatcher
  input                            in_valid,
  input  exec_pkg::alu_op_t        in_op,
  input        [`EXEC_DATA_W-1:0]  in_a,
  input        [`EXEC_DATA_W-1:0]  in_b,
  input        [`EXEC_TAG_W-1:0]   in_tag,
  // to reorder buffer
  output logic                     out_valid,
  output logic [`EXEC_TAG_W-1:0]   out_tag,
  output logic [`EXEC_DATA_W-1:0]  out_data
);

  localparam int DEPTH = `EXEC_LANE_DEPTH;

  // stage 0 holds the operation, later stages hold the result
  logic [DEPTH-1:0]        v_q;
  logic [`EXEC_TAG_W-1:0]  tag_q [DEPTH];
  exec_pkg::alu_op_t       op_q;
  logic [`EXEC_DATA_W-1:0] a_q;
  logic [`EXEC_DATA_W-1:0] b_q;
  logic [`EXEC_DATA_W-1:0] res_q [1:DEPTH-1];

  function automatic logic [`EXEC_DATA_W-1:0] alu_calc(
    input exec_pkg::alu_op_t       op,
    input logic [`EXEC_DATA_W-1:0] a,
    input logic [`EXEC_DATA_W-1:0] b
  );
    logic [`EXEC_DATA_W-1:0] r;
    case (op)
      exec_pkg::op_add: r = a + b;
      exec_pkg::op_sub: r = a - b;
      exec_pkg::op_and: r = a & b;
      exec_pkg::op_xor: r = a ^ b;
      exec_pkg::op_mul: r = a * b;  // low word only
      default:          r = '0;
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////
  // valid shift chain
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[DEPTH-2:0], in_valid};
    end
  end

  // payload, loaded only for this lane's slot
  always_ff @(posedge clock) begin
    if (in_valid) begin
      tag_q[0] <= in_tag;
      op_q     <= in_op;
      a_q      <= in_a;
      b_q      <= in_b;
    end
    tag_q[1] <= tag_q[0];
    res_q[1] <= alu_calc(op_q, a_q, b_q);
    for (int s = 2; s < DEPTH; s++) begin
      tag_q[s] <= tag_q[s-1];
      res_q[s] <= res_q[s-1];
    end
  end

  assign out_valid = v_q[DEPTH-1];
  assign out_tag   = tag_q[DEPTH-1];
  assign out_data  = res_q[DEPTH-1];

endmodule

// File: issue_dispatch.sv
`timescale 1ns/1ns
`include "exec_defs.svh"

module issue_dispatch (
  input                                clock,
  input                                reset,
  // issue side
  input                                issue_valid,
  input  exec_pkg::alu_op_t            issue_op,
  input        [`EXEC_DATA_W-1:0]      issue_a,
  input        [`EXEC_DATA_W-1:0]      issue_b,
  output logic                         issue_ready,
  // reorder buffer
  input                                rob_full,
  input        [`EXEC_TAG_W-1:0]       alloc_tag,
  output logic                         alloc,
  // lanes
  output logic [`EXEC_NUM_LANES-1:0]   lane_valid,
  output exec_pkg::alu_op_t            lane_op,
  output logic [`EXEC_DATA_W-1:0]      lane_a,
  output logic [`EXEC_DATA_W-1:0]      lane_b,
  output logic [`EXEC_TAG_W-1:0]       lane_tag
);

  localparam int LANE_W = (`EXEC_NUM_LANES > 1) ? $clog2(`EXEC_NUM_LANES) : 1;
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`EXEC_NUM_LANES - 1);

  logic              accept;
  logic [LANE_W-1:0] lane_ptr_q;

  assign issue_ready = !rob_full;
  assign accept      = issue_valid && !rob_full;
  assign alloc       = accept;  // one strobe per accepted op

  //////////////////////////////////////////////////
  // round robin steering
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      lane_ptr_q <= '0;
      lane_valid <= '0;
    end else begin
      lane_valid <= '0;
      if (accept) begin
        lane_valid[lane_ptr_q] <= 1'b1;
        if (lane_ptr_q == LAST_LANE) begin
          lane_ptr_q <= '0;
        end else begin
          lane_ptr_q <= lane_ptr_q + 1'b1;
        end
      end
    end
  end

  // operation register, shared by every lane
  always_ff @(posedge clock) begin
    if (accept) begin
      lane_op  <= issue_op;
      lane_a   <= issue_a;
      lane_b   <= issue_b;
      lane_tag <= alloc_tag;  // tail slot from the rob
    end
  end

endmodule

// File: exec_pkg.sv
package exec_pkg;

  // opcodes, mul keeps the low word
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_mul
  } alu_op_t;

  // reorder entry life cycle
  typedef enum logic [1:0] {
    st_empty,
    st_waiting,
    st_done
  } entry_state_t;

endpackage

// File: exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// cluster shape
`define EXEC_NUM_LANES  4
`define EXEC_LANE_DEPTH 3  // register stages per lane
`define EXEC_ROB_DEPTH  8  // keep a power of two

// widths
`define EXEC_DATA_W 32
`define EXEC_TAG_W  3  // log2 of rob depth

`endif
